// ==== logic/pmp_pkg.sv ====
package pmp_pkg;

  // One configuration byte: R, W, X, mode[1:0], two zero bits, L
  typedef logic [7:0]  pmp_cfg_t;

  // pmpaddr holds byte address bits 33 to 2
  typedef logic [31:0] pmp_addr_t;
  typedef logic [31:0] phys_addr_t;
  typedef logic [3:0]  region_idx_t;

  typedef enum logic [1:0] {
    PMP_OFF   = 2'd0,
    PMP_TOR   = 2'd1,
    PMP_NA4   = 2'd2,
    PMP_NAPOT = 2'd3
  } pmp_mode_e;

  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,
    ACC_WRITE = 2'd1,
    ACC_EXEC  = 2'd2
  } pmp_access_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // Bit positions inside pmp_cfg_t
  localparam int CFG_BIT_R    = 0;
  localparam int CFG_BIT_W    = 1;
  localparam int CFG_BIT_X    = 2;
  localparam int CFG_MODE_LSB = 3;
  localparam int CFG_ZERO_LSB = 5;
  localparam int CFG_BIT_L    = 7;

  function automatic pmp_mode_e cfg_mode(pmp_cfg_t cfg);
    return pmp_mode_e'(cfg[CFG_MODE_LSB +: 2]);
  endfunction

  function automatic logic cfg_locked(pmp_cfg_t cfg);
    return cfg[CFG_BIT_L];
  endfunction

endpackage

// ==== logic/pmp_csr_pkg.sv ====
package pmp_csr_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // Four config bytes per pmpcfg CSR, one pmpaddr CSR per region
  localparam csr_addr_t CSR_PMPCFG_BASE  = 12'h3A0;
  localparam csr_addr_t CSR_PMPADDR_BASE = 12'h3B0;

endpackage

// ==== logic/pmp_check_if.sv ====
`timescale 1ns/1ps

interface pmp_check_if
  import pmp_pkg::*;
();

  logic        valid;
  logic        ready;
  phys_addr_t  addr;
  pmp_access_e access;
  priv_lvl_e   priv;

  // Request register side
  modport stage (output valid, addr, access, priv, input ready);

  // Per-region matchers only look at the request fields
  modport match (input addr, access, priv);

  // Priority resolver and output register
  modport resolve (input valid, addr, access, priv, output ready);

endinterface

// ==== logic/pmp_csr_regs.sv ====
`timescale 1ns/1ps

module pmp_csr_regs
  import pmp_pkg::*;
  import pmp_csr_pkg::*;
#(
  parameter int NUM_REGIONS = 8,
  parameter int GRANULARITY = 2
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      csr_we_i,
  input  csr_addr_t csr_addr_i,
  input  csr_data_t csr_wdata_i,
  output csr_data_t csr_rdata_o,
  output pmp_cfg_t  cfg_o      [NUM_REGIONS],
  output pmp_addr_t addr_o     [NUM_REGIONS],
  output pmp_addr_t tor_base_o [NUM_REGIONS]
);

  // Low address bits forced in the software view
  localparam pmp_addr_t NAPOT_ONES =
    (GRANULARITY >= 2) ? ((32'd1 << (GRANULARITY - 1)) - 32'd1) : 32'd0;
  localparam pmp_addr_t OFF_TOR_ZEROS = (32'd1 << GRANULARITY) - 32'd1;

  pmp_cfg_t               cfg_q  [NUM_REGIONS];
  pmp_addr_t              addr_q [NUM_REGIONS];
  logic [NUM_REGIONS-1:0] tor_lock_above;

  function automatic pmp_cfg_t legalize_cfg(pmp_cfg_t cfg_pre, pmp_cfg_t cfg_new);
    pmp_cfg_t cfg_res;
    cfg_res = cfg_new;
    // W without R is reserved
    if (cfg_new[2:0] inside {3'd2, 3'd6}) begin
      cfg_res[2:0] = cfg_pre[2:0];
    end
    // NA4 only exists at word granularity
    if (GRANULARITY >= 1 && cfg_mode(cfg_new) == PMP_NA4) begin
      cfg_res[CFG_MODE_LSB +: 2] = cfg_pre[CFG_MODE_LSB +: 2];
    end
    if (cfg_locked(cfg_pre)) begin
      cfg_res = cfg_pre;
    end
    cfg_res[CFG_ZERO_LSB +: 2] = 2'b00;
    return cfg_res;
  endfunction

  function automatic pmp_addr_t addr_view(pmp_cfg_t cfg, pmp_addr_t addr);
    if (cfg_mode(cfg) == PMP_NAPOT) begin
      return addr | NAPOT_ONES;
    end
    if (cfg_mode(cfg) inside {PMP_OFF, PMP_TOR}) begin
      return addr & ~OFF_TOR_ZEROS;
    end
    return addr;
  endfunction

  // Entry i-1 address is frozen by a locked TOR entry i
  always_comb begin
    tor_lock_above = '0;
    for (int i = 1; i < NUM_REGIONS; i++) begin
      tor_lock_above[i-1] = cfg_locked(cfg_q[i]) && (cfg_mode(cfg_q[i]) == PMP_TOR);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        cfg_q[i]  <= '0;
        addr_q[i] <= '0;
      end
    end else if (csr_we_i) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (csr_addr_i == csr_addr_t'(CSR_PMPCFG_BASE + i / 4)) begin
          cfg_q[i] <= legalize_cfg(cfg_q[i], csr_wdata_i[8 * (i % 4) +: 8]);
        end
        if (csr_addr_i == csr_addr_t'(CSR_PMPADDR_BASE + i) &&
            !cfg_locked(cfg_q[i]) && !tor_lock_above[i]) begin
          addr_q[i] <= csr_wdata_i;
        end
      end
    end
  end

  // Unmapped CSR numbers read as zero
  always_comb begin
    csr_rdata_o = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (csr_addr_i == csr_addr_t'(CSR_PMPCFG_BASE + i / 4)) begin
        csr_rdata_o[8 * (i % 4) +: 8] = cfg_q[i];
      end
      if (csr_addr_i == csr_addr_t'(CSR_PMPADDR_BASE + i)) begin
        csr_rdata_o = addr_view(cfg_q[i], addr_q[i]);
      end
    end
  end

  always_comb begin
    tor_base_o[0] = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      cfg_o[i]  = cfg_q[i];
      addr_o[i] = addr_q[i];
      if (i > 0) begin
        tor_base_o[i] = addr_q[i-1];
      end
    end
  end

endmodule

// ==== logic/pmp_req_stage.sv ====
`timescale 1ns/1ps

module pmp_req_stage
  import pmp_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  phys_addr_t  req_addr_i,
  input  pmp_access_e req_access_i,
  input  priv_lvl_e   req_priv_i,
  pmp_check_if.stage  chk
);

  logic        valid_q;
  logic        accept;
  phys_addr_t  addr_q;
  pmp_access_e access_q;
  priv_lvl_e   priv_q;

  // Free when empty or when the held request leaves this cycle
  assign req_ready_o = !valid_q || chk.ready;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (chk.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q   <= req_addr_i;
      access_q <= req_access_i;
      priv_q   <= req_priv_i;
    end
  end

  assign chk.valid  = valid_q;
  assign chk.addr   = addr_q;
  assign chk.access = access_q;
  assign chk.priv   = priv_q;

endmodule

// ==== logic/pmp_region_match.sv ====
`timescale 1ns/1ps

module pmp_region_match
  import pmp_pkg::*;
#(
  parameter int GRANULARITY = 2
) (
  input  pmp_cfg_t   cfg_i,
  input  pmp_addr_t  addr_i,
  input  pmp_addr_t  tor_base_i,
  pmp_check_if.match chk,
  output logic       hit_o,
  output logic       permit_o
);

  // Word bits below the grain never take part in a match
  localparam pmp_addr_t GRAIN_MASK = (32'd1 << GRANULARITY) - 32'd1;

  pmp_addr_t req_word;
  pmp_addr_t napot_mask;

  assign req_word = {2'b00, chk.addr[31:2]};

  // Trailing ones plus the first zero above them are don't-care
  assign napot_mask = (addr_i ^ (addr_i + 32'd1)) | GRAIN_MASK;

  always_comb begin
    case (cfg_mode(cfg_i))
      PMP_TOR: begin
        hit_o = (req_word >= (tor_base_i & ~GRAIN_MASK)) &&
                (req_word < (addr_i & ~GRAIN_MASK));
      end
      PMP_NA4: begin
        hit_o = (req_word == addr_i);
      end
      PMP_NAPOT: begin
        hit_o = ((req_word & ~napot_mask) == (addr_i & ~napot_mask));
      end
      default: begin
        hit_o = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (chk.access)
      ACC_READ:  permit_o = cfg_i[CFG_BIT_R];
      ACC_WRITE: permit_o = cfg_i[CFG_BIT_W];
      ACC_EXEC:  permit_o = cfg_i[CFG_BIT_X];
      default:   permit_o = 1'b0;
    endcase
    // M-mode is only bound by locked entries
    if (chk.priv == PRIV_M && !cfg_locked(cfg_i)) begin
      permit_o = 1'b1;
    end
  end

endmodule

// ==== logic/pmp_priority_resolve.sv ====
`timescale 1ns/1ps

module pmp_priority_resolve
  import pmp_pkg::*;
#(
  parameter int NUM_REGIONS = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [NUM_REGIONS-1:0] hit_i,
  input  logic [NUM_REGIONS-1:0] permit_i,
  pmp_check_if.resolve           chk,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic                   rsp_allow_o,
  output logic                   rsp_hit_o,
  output region_idx_t            rsp_region_o
);

  logic        any_hit;
  logic        sel_permit;
  logic        sel_allow;
  region_idx_t sel_idx;

  // Walk downwards so the lowest index is the last one kept
  always_comb begin
    sel_idx    = '0;
    sel_permit = 1'b0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (hit_i[i]) begin
        sel_idx    = region_idx_t'(i);
        sel_permit = permit_i[i];
      end
    end
    any_hit = |hit_i;
    // No match: only M-mode gets through
    sel_allow = any_hit ? sel_permit : (chk.priv == PRIV_M);
  end

  assign chk.ready = !rsp_valid_o || rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o <= 1'b0;
    end else if (chk.valid && chk.ready) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (chk.valid && chk.ready) begin
      rsp_allow_o  <= sel_allow;
      rsp_hit_o    <= any_hit;
      rsp_region_o <= sel_idx;
    end
  end

endmodule

// ==== logic/pmp_top.sv ====
`timescale 1ns/1ps

module pmp_top
  import pmp_pkg::*;
  import pmp_csr_pkg::*;
#(
  parameter int NUM_REGIONS = 8,
  parameter int GRANULARITY = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        csr_we_i,
  input  csr_addr_t   csr_addr_i,
  input  csr_data_t   csr_wdata_i,
  output csr_data_t   csr_rdata_o,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  phys_addr_t  req_addr_i,
  input  pmp_access_e req_access_i,
  input  priv_lvl_e   req_priv_i,
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i,
  output logic        rsp_allow_o,
  output logic        rsp_hit_o,
  output region_idx_t rsp_region_o
);

  pmp_cfg_t               cfg      [NUM_REGIONS];
  pmp_addr_t              addr     [NUM_REGIONS];
  pmp_addr_t              tor_base [NUM_REGIONS];
  logic [NUM_REGIONS-1:0] hit;
  logic [NUM_REGIONS-1:0] permit;

  pmp_check_if chk_if ();

  pmp_csr_regs #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) csr_regs_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .cfg_o       (cfg),
    .addr_o      (addr),
    .tor_base_o  (tor_base)
  );

  pmp_req_stage req_stage_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_addr_i   (req_addr_i),
    .req_access_i (req_access_i),
    .req_priv_i   (req_priv_i),
    .chk          (chk_if)
  );

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : gen_region
    pmp_region_match #(
      .GRANULARITY (GRANULARITY)
    ) region_match_i (
      .cfg_i      (cfg[i]),
      .addr_i     (addr[i]),
      .tor_base_i (tor_base[i]),
      .chk        (chk_if),
      .hit_o      (hit[i]),
      .permit_o   (permit[i])
    );
  end

  pmp_priority_resolve #(
    .NUM_REGIONS (NUM_REGIONS)
  ) resolve_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .hit_i        (hit),
    .permit_i     (permit),
    .chk          (chk_if),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_allow_o  (rsp_allow_o),
    .rsp_hit_o    (rsp_hit_o),
    .rsp_region_o (rsp_region_o)
  );

endmodule

// ==== test/pmp_assert.sv ====
`timescale 1ns/1ps

module pmp_assert
  import pmp_pkg::*;
#(
  parameter int NUM_REGIONS = 8
) (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        req_ready_i,
  input logic        rsp_valid_i,
  input logic        rsp_ready_i,
  input logic        rsp_allow_i,
  input logic        rsp_hit_i,
  input region_idx_t rsp_region_i,
  input pmp_cfg_t    cfg_i [NUM_REGIONS]
);

  // A stalled response keeps its valid and its data
  rsp_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_allow_i) &&
                                    $stable(rsp_hit_i) && $stable(rsp_region_i))
    else $error("Response changed while stalled");

  rsp_reset_a : assert property (@(posedge clk_i) !rst_ni |-> !rsp_valid_i)
    else $error("Response valid during reset");

  // Empty output register means the request path can move
  req_ready_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rsp_valid_i |-> req_ready_i)
    else $error("Request not ready with empty output register");

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : gen_lock
    lock_kept_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      cfg_i[i][CFG_BIT_L] |=> cfg_i[i][CFG_BIT_L])
      else $error("Lock bit of region %0d cleared", i);
  end

endmodule

// ==== test/pmp_checker.sv ====
`timescale 1ns/1ps

module pmp_checker
  import pmp_pkg::*;
  import pmp_csr_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  csr_addr_t   csr_addr_i,
  input  csr_data_t   csr_rdata_i,
  input  logic        rd_check_i,
  input  csr_data_t   rd_exp_i,
  input  logic        exp_push_i,
  input  logic        exp_allow_i,
  input  logic        exp_hit_i,
  input  region_idx_t exp_region_i,
  input  logic        rsp_valid_i,
  input  logic        rsp_ready_i,
  input  logic        rsp_allow_i,
  input  logic        rsp_hit_i,
  input  region_idx_t rsp_region_i,
  output int          pending_o,
  output int          csr_err_o,
  output int          rsp_err_o
);

  // Expected {allow, hit, region} in request order
  logic [5:0] exp_q [$];
  logic [5:0] exp_val;
  int         rsp_cnt;

  initial begin
    pending_o = 0;
    csr_err_o = 0;
    rsp_err_o = 0;
    rsp_cnt   = 0;
  end

  always @(posedge clk_i) begin
    if (rst_ni && rd_check_i && csr_rdata_i !== rd_exp_i) begin
      $display("FAILED %0t: CSR 0x%03h read 0x%08h, expected 0x%08h",
               $time, csr_addr_i, csr_rdata_i, rd_exp_i);
      csr_err_o++;
    end
    if (rst_ni && rsp_valid_i && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Response at %0t arrived with no request outstanding", $time);
        rsp_err_o++;
      end else begin
        exp_val = exp_q.pop_front();
        // Region number only means something on a hit
        if (rsp_allow_i !== exp_val[5] || rsp_hit_i !== exp_val[4] ||
            (exp_val[4] && rsp_region_i !== exp_val[3:0])) begin
          $display("FAILED %0t: response %0d allow %0b hit %0b region %0d, %s %0b %0b %0d",
                   $time, rsp_cnt, rsp_allow_i, rsp_hit_i, rsp_region_i,
                   "expected", exp_val[5], exp_val[4], exp_val[3:0]);
          rsp_err_o++;
        end
      end
      rsp_cnt++;
    end
    if (exp_push_i) begin
      exp_q.push_back({exp_allow_i, exp_hit_i, exp_region_i});
    end
    pending_o = exp_q.size();
  end

endmodule

// ==== test/pmp_tb.sv ====
`timescale 1ns/1ps

module pmp_tb
  import pmp_pkg::*;
  import pmp_csr_pkg::*;
();

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_CHECK} op_e;

  typedef struct packed {
    op_e         op;
    csr_addr_t   csr;
    csr_data_t   data;
    phys_addr_t  addr;
    pmp_access_e acc;
    priv_lvl_e   priv;
    logic        allow;
    logic        hit;
    region_idx_t region;
  } entry_t;

  localparam csr_addr_t PMPCFG0 = CSR_PMPCFG_BASE;
  localparam csr_addr_t PMPCFG1 = CSR_PMPCFG_BASE + 12'd1;

  logic        clk_i;
  logic        rst_ni;
  logic        csr_we_i;
  csr_addr_t   csr_addr_i;
  csr_data_t   csr_wdata_i;
  csr_data_t   csr_rdata_o;
  logic        req_valid_i;
  logic        req_ready_o;
  phys_addr_t  req_addr_i;
  pmp_access_e req_access_i;
  priv_lvl_e   req_priv_i;
  logic        rsp_valid_o;
  logic        rsp_ready_i;
  logic        rsp_allow_o;
  logic        rsp_hit_o;
  region_idx_t rsp_region_o;

  logic        rd_check;
  csr_data_t   rd_exp;
  logic        exp_push;
  logic        exp_allow;
  logic        exp_hit;
  region_idx_t exp_region;
  int          pending;
  int          csr_err;
  int          rsp_err;

  entry_t      stim_q [$];
  logic [31:0] rng;
  int          cycle_cnt;
  int          cycle_limit;

  pmp_top #(
    .NUM_REGIONS (8),
    .GRANULARITY (2)
  ) pmp_top_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .csr_we_i     (csr_we_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_addr_i   (req_addr_i),
    .req_access_i (req_access_i),
    .req_priv_i   (req_priv_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_allow_o  (rsp_allow_o),
    .rsp_hit_o    (rsp_hit_o),
    .rsp_region_o (rsp_region_o)
  );

  pmp_checker checker_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .csr_addr_i   (csr_addr_i),
    .csr_rdata_i  (csr_rdata_o),
    .rd_check_i   (rd_check),
    .rd_exp_i     (rd_exp),
    .exp_push_i   (exp_push),
    .exp_allow_i  (exp_allow),
    .exp_hit_i    (exp_hit),
    .exp_region_i (exp_region),
    .rsp_valid_i  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_allow_i  (rsp_allow_o),
    .rsp_hit_i    (rsp_hit_o),
    .rsp_region_i (rsp_region_o),
    .pending_o    (pending),
    .csr_err_o    (csr_err),
    .rsp_err_o    (rsp_err)
  );

  bind pmp_top pmp_assert #(
    .NUM_REGIONS (NUM_REGIONS)
  ) assert_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_ready_i  (req_ready_o),
    .rsp_valid_i  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_allow_i  (rsp_allow_o),
    .rsp_hit_i    (rsp_hit_o),
    .rsp_region_i (rsp_region_o),
    .cfg_i        (cfg)
  );

  function automatic logic [31:0] next_random(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic csr_addr_t pmpaddr_csr(int n);
    return CSR_PMPADDR_BASE + csr_addr_t'(n);
  endfunction

  function automatic void add_write(csr_addr_t a, csr_data_t d);
    entry_t e;
    e      = '0;
    e.op   = OP_WRITE;
    e.csr  = a;
    e.data = d;
    stim_q.push_back(e);
  endfunction

  function automatic void add_read(csr_addr_t a, csr_data_t d);
    entry_t e;
    e      = '0;
    e.op   = OP_READ;
    e.csr  = a;
    e.data = d;
    stim_q.push_back(e);
  endfunction

  function automatic void add_check(phys_addr_t a, pmp_access_e acc, priv_lvl_e priv,
                                    logic allow, logic hit, region_idx_t region);
    entry_t e;
    e        = '0;
    e.op     = OP_CHECK;
    e.addr   = a;
    e.acc    = acc;
    e.priv   = priv;
    e.allow  = allow;
    e.hit    = hit;
    e.region = region;
    stim_q.push_back(e);
  endfunction

  function automatic void build_table();
    // WARL legalization in pmpcfg1, region 4 byte first
    add_write(PMPCFG1, 32'h0000_0019);
    add_read(PMPCFG1, 32'h0000_0019);
    add_write(PMPCFG1, 32'h0000_001A);
    add_read(PMPCFG1, 32'h0000_0019);
    add_write(PMPCFG1, 32'h0000_001E);
    add_read(PMPCFG1, 32'h0000_0019);
    add_write(PMPCFG1, 32'h0000_0013);
    add_read(PMPCFG1, 32'h0000_001B);
    add_write(PMPCFG1, 32'h0000_006F);
    add_read(PMPCFG1, 32'h0000_000F);
    add_write(PMPCFG1, 32'h0E00_0000);
    add_read(PMPCFG1, 32'h0800_0000);
    add_write(PMPCFG1, 32'h0000_0000);
    add_read(PMPCFG1, 32'h0000_0000);
    // Unmapped CSR
    add_write(12'h3C0, 32'hFFFF_FFFF);
    add_read(12'h3C0, 32'h0000_0000);
    // Granularity view on region 1, stored word keeps bit 1
    add_write(pmpaddr_csr(1), 32'h0000_1236);
    add_read(pmpaddr_csr(1), 32'h0000_1234);
    add_write(PMPCFG0, 32'h0000_1800);
    add_read(pmpaddr_csr(1), 32'h0000_1237);
    add_write(PMPCFG0, 32'h0000_0800);
    add_read(pmpaddr_csr(1), 32'h0000_1234);
    add_write(PMPCFG0, 32'h0000_1800);
    add_read(pmpaddr_csr(1), 32'h0000_1237);
    // Region map for access checks
    add_write(pmpaddr_csr(0), 32'h0000_05FF);
    add_write(pmpaddr_csr(1), 32'h0000_07FF);
    add_write(pmpaddr_csr(2), 32'h0000_2000);
    add_write(pmpaddr_csr(3), 32'h0000_2400);
    add_write(pmpaddr_csr(4), 32'h0000_23FF);
    add_write(PMPCFG0, 32'h0B00_1F19);
    add_write(PMPCFG1, 32'h0000_001C);
    add_read(PMPCFG0, 32'h0B00_1F19);
    add_check(32'hF000_0000, ACC_READ, PRIV_U, 1'b0, 1'b0, 4'd0);
    add_check(32'hF000_0000, ACC_READ, PRIV_M, 1'b1, 1'b0, 4'd0);
    add_check(32'h0000_1800, ACC_WRITE, PRIV_U, 1'b0, 1'b1, 4'd0);
    add_check(32'h0000_1800, ACC_READ, PRIV_U, 1'b1, 1'b1, 4'd0);
    add_check(32'h0000_2000, ACC_WRITE, PRIV_U, 1'b1, 1'b1, 4'd1);
    add_check(32'h0000_8000, ACC_READ, PRIV_U, 1'b1, 1'b1, 4'd3);
    add_check(32'h0000_8FFC, ACC_WRITE, PRIV_U, 1'b1, 1'b1, 4'd3);
    add_check(32'h0000_9000, ACC_READ, PRIV_U, 1'b0, 1'b1, 4'd4);
    add_check(32'h0000_9000, ACC_EXEC, PRIV_U, 1'b1, 1'b1, 4'd4);
    add_check(32'h0000_7FFC, ACC_READ, PRIV_U, 1'b0, 1'b0, 4'd0);
    add_check(32'h0000_1800, ACC_WRITE, PRIV_M, 1'b1, 1'b1, 4'd0);
    add_check(32'h0000_8FFC, ACC_EXEC, PRIV_U, 1'b0, 1'b1, 4'd3);
    // Lock region 0
    add_write(PMPCFG0, 32'h0B00_1F99);
    add_read(PMPCFG0, 32'h0B00_1F99);
    add_check(32'h0000_1800, ACC_WRITE, PRIV_M, 1'b0, 1'b1, 4'd0);
    add_check(32'h0000_1800, ACC_READ, PRIV_M, 1'b1, 1'b1, 4'd0);
    add_write(PMPCFG0, 32'h0B00_1F1F);
    add_read(PMPCFG0, 32'h0B00_1F99);
    add_write(pmpaddr_csr(0), 32'h0000_0123);
    add_read(pmpaddr_csr(0), 32'h0000_05FF);
    // Locked TOR region 3 freezes pmpaddr2 but not cfg byte 2
    add_write(PMPCFG0, 32'h8B00_1F99);
    add_read(PMPCFG0, 32'h8B00_1F99);
    add_write(pmpaddr_csr(2), 32'h0000_1234);
    add_read(pmpaddr_csr(2), 32'h0000_2000);
    add_write(pmpaddr_csr(3), 32'h0000_3000);
    add_read(pmpaddr_csr(3), 32'h0000_2400);
    add_write(PMPCFG0, 32'h8B01_1F99);
    add_read(PMPCFG0, 32'h8B01_1F99);
    // Back-to-back burst
    add_check(32'h0000_8000, ACC_WRITE, PRIV_M, 1'b1, 1'b1, 4'd3);
    add_check(32'h0000_8000, ACC_EXEC, PRIV_M, 1'b0, 1'b1, 4'd3);
    add_check(32'h0000_9FFC, ACC_EXEC, PRIV_M, 1'b1, 1'b1, 4'd4);
    add_check(32'h0000_3FFC, ACC_WRITE, PRIV_U, 1'b1, 1'b1, 4'd1);
    add_check(32'h0000_4000, ACC_WRITE, PRIV_U, 1'b0, 1'b0, 4'd0);
    add_check(32'h0000_0FFC, ACC_EXEC, PRIV_U, 1'b1, 1'b1, 4'd1);
    add_check(32'h0000_1000, ACC_EXEC, PRIV_M, 1'b0, 1'b1, 4'd0);
    add_check(32'h0000_A000, ACC_READ, PRIV_M, 1'b1, 1'b0, 4'd0);
  endfunction

  // Holds until every issued check has answered
  task automatic wait_drain();
    while (pending != 0 || rsp_valid_o) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic csr_write(entry_t e);
    wait_drain();
    csr_we_i    = 1'b1;
    csr_addr_i  = e.csr;
    csr_wdata_i = e.data;
    @(posedge clk_i);
    #1;
    csr_we_i = 1'b0;
  endtask

  task automatic csr_read(entry_t e);
    csr_addr_i = e.csr;
    rd_exp     = e.data;
    rd_check   = 1'b1;
    @(posedge clk_i);
    #1;
    rd_check = 1'b0;
  endtask

  task automatic run_check(entry_t e);
    logic accepted;
    req_valid_i  = 1'b1;
    req_addr_i   = e.addr;
    req_access_i = e.acc;
    req_priv_i   = e.priv;
    exp_push     = 1'b1;
    exp_allow    = e.allow;
    exp_hit      = e.hit;
    exp_region   = e.region;
    accepted     = 1'b0;
    while (!accepted) begin
      // Ready is settled well before the edge
      #2;
      accepted = req_ready_o;
      @(posedge clk_i);
      #1;
      exp_push = 1'b0;
    end
    req_valid_i = 1'b0;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    rsp_ready_i = 1'b0;
    rng         = 32'heb77;
    forever begin
      @(posedge clk_i);
      #1;
      rng         = next_random(rng);
      rsp_ready_i = (rng[1:0] != 2'b00);
    end
  end

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("ERRORS FOUND");
        $finish;
      end
    end
  end

  initial begin
    rst_ni       = 1'b0;
    csr_we_i     = 1'b0;
    csr_addr_i   = '0;
    csr_wdata_i  = '0;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    req_access_i = ACC_READ;
    req_priv_i   = PRIV_U;
    rd_check     = 1'b0;
    rd_exp       = '0;
    exp_push     = 1'b0;
    exp_allow    = 1'b0;
    exp_hit      = 1'b0;
    exp_region   = '0;
    build_table();
    cycle_limit = stim_q.size() * 8 + 100;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    foreach (stim_q[k]) begin
      case (stim_q[k].op)
        OP_WRITE: csr_write(stim_q[k]);
        OP_READ:  csr_read(stim_q[k]);
        default:  run_check(stim_q[k]);
      endcase
    end
    wait_drain();
    $display("Error count: %0d CSR read, %0d response", csr_err, rsp_err);
    if (csr_err == 0 && rsp_err == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
logic/pmp_pkg.sv
logic/pmp_csr_pkg.sv
logic/pmp_check_if.sv
logic/pmp_csr_regs.sv
logic/pmp_req_stage.sv
logic/pmp_region_match.sv
logic/pmp_priority_resolve.sv
logic/pmp_top.sv
test/pmp_assert.sv
test/pmp_checker.sv
test/pmp_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the PMP testbench with Verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module pmp_tb -f tb.f -o pmp_sim &&
  ./obj_dir/pmp_sim | tee /dev/stderr | grep -qx "NO ERRORS" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
